// ==== src/cam_cfg_pkg.sv ====
package cam_cfg_pkg;

    // sccb master states
    typedef enum logic [1:0] {
        idle,
        send,
        send_done,
        clear_update
    } sccb_state_t;

    // sensor output formats
    typedef enum logic [1:0] {
        yuv422,
        rgb565,
        raw8,
        jpeg
    } img_mode_t;

    // host register map
    localparam logic REG_CTRL  = 1'b0;
    localparam logic REG_CLKRC = 1'b1;

    // sensor write id on the bus
    localparam logic [7:0] CAM_WRITE_ADDR = 8'h60;

    // end of command table
    localparam logic [15:0] CMD_END = 16'hFFFF;

    // output size codes per resolution, in units of 8 pixels
    // 160x120 176x144 320x240 352x288 640x480 800x600 1024x768 1280x1024
    localparam logic [7:0] OUT_W_CODE [8] = '{
        8'h14, 8'h16, 8'h28, 8'h2C, 8'h50, 8'h64, 8'h80, 8'hA0
    };
    localparam logic [7:0] OUT_H_CODE [8] = '{
        8'h0F, 8'h12, 8'h1E, 8'h24, 8'h3C, 8'h4B, 8'h60, 8'h80
    };

endpackage

// ==== src/cam_ctrl_regs.sv ====
`timescale 1ns/100ps

module cam_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr,
    input  logic                  wr_addr,
    input  logic [7:0]            wr_data,
    input  logic                  rd_addr,
    input  logic                  clr_update,
    output logic [7:0]            rd_data,
    output logic                  update,
    output logic                  test_pattern,
    output cam_cfg_pkg::img_mode_t image_mode,
    output logic [2:0]            resolution,
    output logic [6:0]            clkrc
);

    import cam_cfg_pkg::*;

    //////////////////////////////
    // control register
    //////////////////////////////

    // ctrl layout: [0] update, [1] test pattern, [3:2] mode, [6:4] resolution
    always_ff @(posedge clk) begin
        if (rst) begin
            update       <= 1'b0;
            test_pattern <= 1'b0;
            image_mode   <= yuv422;
            resolution   <= 3'd0;
        end else begin
            if (wr && (wr_addr == REG_CTRL)) begin
                update       <= wr_data[0];
                test_pattern <= wr_data[1];
                image_mode   <= img_mode_t'(wr_data[3:2]);
                resolution   <= wr_data[6:4];
            end
            // master clear beats a host write in the same cycle
            if (clr_update) begin
                update <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // prescaler register
    //////////////////////////////

    // prescaler comes up as 1
    always_ff @(posedge clk) begin
        if (rst) begin
            clkrc <= 7'd1;
        end else if (wr && (wr_addr == REG_CLKRC)) begin
            clkrc <= wr_data[6:0];
        end
    end

    // read-back, top bits padded with zero
    always_comb begin
        case (rd_addr)
            REG_CTRL:  rd_data = {1'b0, resolution, image_mode, test_pattern, update};
            REG_CLKRC: rd_data = {1'b0, clkrc};
            default:   rd_data = 8'h00;
        endcase
    end

endmodule

// ==== src/cam_cmd_table.sv ====
`timescale 1ns/100ps

module cam_cmd_table (
    input  logic [3:0]             cmd_idx,
    input  logic                   test_pattern,
    input  cam_cfg_pkg::img_mode_t image_mode,
    input  logic [2:0]             resolution,
    input  logic [6:0]             clkrc,
    output logic [15:0]            cmd
);

    import cam_cfg_pkg::*;

    //////////////////////////////
    // sensor register addresses
    //////////////////////////////

    // bank select, shared by both banks
    localparam logic [7:0] ADDR_BANK_SEL = 8'hFF;
    // sensor bank
    localparam logic [7:0] ADDR_CLKRC    = 8'h11;
    localparam logic [7:0] ADDR_COM7     = 8'h12;
    // dsp bank
    localparam logic [7:0] ADDR_IMG_MODE = 8'hDA;
    localparam logic [7:0] ADDR_ZMOW     = 8'h5A;
    localparam logic [7:0] ADDR_ZMOH     = 8'h5B;

    // bank select values
    localparam logic [7:0] BANK_DSP    = 8'h00;
    localparam logic [7:0] BANK_SENSOR = 8'h01;

    //////////////////////////////
    // table body
    //////////////////////////////

    // pairs are {register, value}, settings are read live
    always_comb begin
        case (cmd_idx)
            // switch to sensor bank
            4'd0: cmd = {ADDR_BANK_SEL, BANK_SENSOR};
            // clock prescaler, bit 7 kept low
            4'd1: cmd = {ADDR_CLKRC, 1'b0, clkrc};
            // resolution in [6:4], color bar enable in [1]
            4'd2: cmd = {ADDR_COM7, 1'b0, resolution, 2'b00, test_pattern, 1'b0};
            // switch to dsp bank
            4'd3: cmd = {ADDR_BANK_SEL, BANK_DSP};
            // output format select
            4'd4: cmd = {ADDR_IMG_MODE, 6'b000000, image_mode};
            // output width code
            4'd5: cmd = {ADDR_ZMOW, OUT_W_CODE[resolution]};
            // output height code
            4'd6: cmd = {ADDR_ZMOH, OUT_H_CODE[resolution]};
            // past the last pair
            default: cmd = CMD_END;
        endcase
    end

endmodule

// ==== src/sccb_master.sv ====
`timescale 1ns/100ps

module sccb_master #(
    parameter int SCL_DIV_W = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        update,
    input  logic [15:0] cmd,
    output logic [3:0]  cmd_idx,
    output logic        sioc,
    inout  wire         siod,
    output logic        clr_update,
    output logic        config_finished
);

    import cam_cfg_pkg::*;

    sccb_state_t          state;

    // bit period counter, also the power-up wait
    logic [SCL_DIV_W-1:0] divider;
    // frame bits, msb on the line
    logic [31:0]          data_sr;
    // one per live bit period
    logic [31:0]          busy_sr;

    logic [1:0]           quarter;
    logic [5:0]           edge_bits;
    logic                 sioc_pat;
    logic                 dont_care;

    //////////////////////////////
    // data line
    //////////////////////////////

    // don't-care bit after id, after register and after value
    assign dont_care = (busy_sr[11:10] == 2'b10) ||
                       (busy_sr[20:19] == 2'b10) ||
                       (busy_sr[29:28] == 2'b10);

    // released so the camera may answer, pulled up on the board
    assign siod = dont_care ? 1'bz : data_sr[31];

    //////////////////////////////
    // clock shaping
    //////////////////////////////

    // position inside the current bit period
    assign quarter   = divider[SCL_DIV_W-1 -: 2];
    // head and tail of busy tell start, stop and data periods apart
    assign edge_bits = {busy_sr[31:29], busy_sr[2:0]};

    always_comb begin
        case (edge_bits)
            // first two periods, clock high while data falls
            6'b111_111: sioc_pat = 1'b1;
            6'b111_110: sioc_pat = 1'b1;
            // third period, clock drops to close the start
            6'b111_100: sioc_pat = 1'b0;
            // clock rises with data still low
            6'b110_000: sioc_pat = (quarter != 2'b00);
            // last period, data rises under high clock
            6'b100_000: sioc_pat = 1'b1;
            // nothing on the bus
            6'b000_000: sioc_pat = 1'b1;
            // data bit, low at the edges and high in the middle
            default:    sioc_pat = (quarter == 2'b01) || (quarter == 2'b10);
        endcase
    end

    //////////////////////////////
    // control FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= idle;
            divider         <= SCL_DIV_W'(1);
            data_sr         <= '1;
            busy_sr         <= '0;
            cmd_idx         <= 4'd0;
            sioc            <= 1'b1;
            clr_update      <= 1'b0;
            config_finished <= 1'b0;
        end else begin
            clr_update      <= 1'b0;
            // finished only when parked and no new request
            config_finished <= (state == idle) && !update;

            case (state)
                idle: begin
                    sioc <= 1'b1;
                    if (update) begin
                        state <= send;
                    end
                end

                send: begin
                    sioc <= sioc_pat;
                    if (!busy_sr[31]) begin
                        // between frames
                        if (divider == '0) begin
                            if (cmd == CMD_END) begin
                                state <= send_done;
                            end else begin
                                // start, id, dc, reg, dc, value, dc, stop
                                data_sr <= {3'b100, CAM_WRITE_ADDR, 1'b0,
                                            cmd[15:8], 1'b0,
                                            cmd[7:0], 1'b0, 2'b01};
                                busy_sr <= '1;
                                cmd_idx <= cmd_idx + 4'd1;
                            end
                        end else begin
                            // only counts after reset, divider idles at zero
                            divider <= divider + 1'b1;
                        end
                    end else begin
                        // wraps to zero at the end of each bit period
                        divider <= divider + 1'b1;
                        if (divider == '1) begin
                            busy_sr <= {busy_sr[30:0], 1'b0};
                            data_sr <= {data_sr[30:0], 1'b1};
                        end
                    end
                end

                send_done: begin
                    sioc       <= 1'b1;
                    cmd_idx    <= 4'd0;
                    // one-cycle clear of the host update bit
                    clr_update <= 1'b1;
                    state      <= clear_update;
                end

                clear_update: begin
                    sioc  <= 1'b1;
                    state <= idle;
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== src/cam_cfg_top.sv ====
`timescale 1ns/100ps

module cam_cfg_top #(
    parameter int SCL_DIV_W = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  logic       wr_addr,
    input  logic [7:0] wr_data,
    input  logic       rd_addr,
    output logic [7:0] rd_data,
    output logic       sioc,
    inout  wire        siod,
    output logic       config_finished
);

    import cam_cfg_pkg::*;

    // control levels
    logic        update;
    logic        test_pattern;
    img_mode_t   image_mode;
    logic [2:0]  resolution;
    logic [6:0]  clkrc;

    // master handshake with regs and table
    logic        clr_update;
    logic [3:0]  cmd_idx;
    logic [15:0] cmd;

    cam_ctrl_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_addr      (rd_addr),
        .clr_update   (clr_update),
        .rd_data      (rd_data),
        .update       (update),
        .test_pattern (test_pattern),
        .image_mode   (image_mode),
        .resolution   (resolution),
        .clkrc        (clkrc)
    );

    cam_cmd_table u_table (
        .cmd_idx      (cmd_idx),
        .test_pattern (test_pattern),
        .image_mode   (image_mode),
        .resolution   (resolution),
        .clkrc        (clkrc),
        .cmd          (cmd)
    );

    sccb_master #(
        .SCL_DIV_W (SCL_DIV_W)
    ) u_master (
        .clk             (clk),
        .rst             (rst),
        .update          (update),
        .cmd             (cmd),
        .cmd_idx         (cmd_idx),
        .sioc            (sioc),
        .siod            (siod),
        .clr_update      (clr_update),
        .config_finished (config_finished)
    );

endmodule

// ==== verif/sccb_master_assert.sv ====
`timescale 1ns/100ps

module sccb_master_assert (
    input logic        clk,
    input logic        rst,
    input logic        sioc,
    input logic        siod,
    input logic [31:0] busy_sr,
    input logic        update,
    input logic        clr_update,
    input logic        config_finished
);

    // start and stop periods as seen right after the shift
    logic start_per;
    logic stop_per;

    assign start_per = (busy_sr[31:29] == 3'b111) && (busy_sr[2:0] == 3'b110);
    assign stop_per  = (busy_sr[31:29] == 3'b100);

    // clear is a single pulse and takes the request down
    clr_pulse: assert property (@(posedge clk) disable iff (rst)
        clr_update |=> (!clr_update && !update))
        else $error("clr_update held high or update not cleared");

    // data moves under low clock except at start and stop
    siod_stable: assert property (@(posedge clk) disable iff (rst)
        $changed(siod) |-> (!sioc || start_per || stop_per))
        else $error("siod changed while sioc high");

    // a new request drops finished at once and stays pending
    done_vs_update: assert property (@(posedge clk) disable iff (rst)
        (config_finished && update) |=> (!config_finished && update))
        else $error("config_finished high while update pending");

endmodule

bind sccb_master sccb_master_assert u_assert (
    .clk             (clk),
    .rst             (rst),
    .sioc            (sioc),
    .siod            (siod),
    .busy_sr         (busy_sr),
    .update          (update),
    .clr_update      (clr_update),
    .config_finished (config_finished)
);

// ==== verif/cam_cfg_tb.sv ====
`timescale 1ns/100ps

module cam_cfg_tb;

    import cam_cfg_pkg::*;

    localparam int SCL_DIV_W   = 4;
    localparam int CLK_NS      = 4;
    localparam int BIT_CYC     = 1 << SCL_DIV_W;
    localparam int QTR_CYC     = BIT_CYC / 4;
    localparam int FRAME_NS    = 32 * BIT_CYC * CLK_NS;
    localparam int N_RUNS      = 5;
    localparam int WATCHDOG_NS = (N_RUNS * 8 * FRAME_NS * 3) / 2 + BIT_CYC * CLK_NS + 10 * CLK_NS;

    logic       clk;
    logic       rst;
    logic       wr;
    logic       wr_addr;
    logic [7:0] wr_data;
    logic       rd_addr;
    logic [7:0] rd_data;
    logic       sioc;
    logic       config_finished;
    wire        siod;

    // camera side of the data line
    logic cam_low;
    assign siod = cam_low ? 1'b0 : 1'bz;
    pullup (siod);

    cam_cfg_top #(
        .SCL_DIV_W (SCL_DIV_W)
    ) UUT (
        .clk             (clk),
        .rst             (rst),
        .wr              (wr),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .sioc            (sioc),
        .siod            (siod),
        .config_finished (config_finished)
    );

    // settings of the current run
    logic        exp_tp;
    img_mode_t   exp_mode;
    logic [2:0]  exp_res;
    logic [6:0]  exp_clkrc;

    int          n_errors;
    int          n_checks;
    int          run_frames;
    int          total_frames;
    int          release_errs;
    int          dc_seen;
    logic [31:0] lfsr;

    // decoder state
    logic [23:0] frame_q [$];
    logic [23:0] rx_frame;
    logic [31:0] rx_bits;
    int          rx_count;
    logic        in_frame;
    event        frame_done;
    event        dc_next;

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // expected {register, value} at one table index
    function automatic logic [15:0] exp_cmd(input int idx, input logic tp,
                                            input img_mode_t mode, input logic [2:0] res,
                                            input logic [6:0] ck);
        case (idx)
            0:       exp_cmd = 16'hFF01;
            1:       exp_cmd = {8'h11, 1'b0, ck};
            2:       exp_cmd = {8'h12, 1'b0, res, 2'b00, tp, 1'b0};
            3:       exp_cmd = 16'hFF00;
            4:       exp_cmd = {8'hDA, 6'd0, mode};
            5:       exp_cmd = {8'h5A, OUT_W_CODE[res]};
            6:       exp_cmd = {8'h5B, OUT_H_CODE[res]};
            default: exp_cmd = 16'hFFFF;
        endcase
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        n_errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic write_reg(input logic addr, input logic [7:0] data);
        @(negedge clk);
        wr      = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr      = 1'b0;
    endtask

    task automatic read_reg(input logic addr, output logic [7:0] data);
        @(negedge clk);
        rd_addr = addr;
        #(CLK_NS / 4);
        data = rd_data;
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("test %s: done, %0d errors", name, n_errors - errs_before);
    endtask

    //////////////////////////////
    // sccb decoder
    //////////////////////////////

    // start when data falls under high clock
    always @(negedge siod) begin
        if (sioc === 1'b1) begin
            in_frame = 1'b1;
            rx_count = 0;
            rx_bits  = '0;
        end
    end

    // stop when data rises under high clock
    // 27 frame bits plus the stop lead-in
    always @(posedge siod) begin
        if (sioc === 1'b1 && in_frame) begin
            in_frame = 1'b0;
            if (rx_count != 28) begin
                report_error($sformatf("malformed frame with %0d clock pulses", rx_count));
            end else begin
                frame_q.push_back({rx_bits[27:20], rx_bits[18:11], rx_bits[9:2]});
                -> frame_done;
            end
        end
    end

    always @(posedge sioc) begin
        if (in_frame) begin
            rx_bits = {rx_bits[30:0], siod};
            rx_count++;
            // camera holds the line low in don't-care bits
            if (rx_count == 9 || rx_count == 18 || rx_count == 27) begin
                dc_seen++;
                if (siod !== 1'b0) begin
                    release_errs++;
                    report_error($sformatf("siod read %b in a don't-care bit", siod));
                end
            end
            if (rx_count == 8 || rx_count == 17 || rx_count == 26) begin
                -> dc_next;
            end
        end
    end

    // pull low from the shift into the dc bit until after its sample
    initial begin
        cam_low = 1'b0;
        forever begin
            @(dc_next);
            @(negedge sioc);
            repeat (QTR_CYC - 1) @(posedge clk);
            @(negedge clk);
            // only the pullup holds the line once the master lets go
            if (siod !== 1'b1) begin
                release_errs++;
                report_error($sformatf("siod not released, read %b", siod));
            end
            cam_low = 1'b1;
            @(posedge sioc);
            @(negedge sioc);
            @(negedge clk);
            cam_low = 1'b0;
        end
    end

    //////////////////////////////
    // comparison
    //////////////////////////////

    always @(frame_done) begin
        rx_frame = frame_q.pop_front();
        check_val("frame id", CAM_WRITE_ADDR, rx_frame[23:16]);
        check_val($sformatf("frame %0d pair", run_frames),
                  exp_cmd(run_frames, exp_tp, exp_mode, exp_res, exp_clkrc), rx_frame[15:0]);
        if (config_finished !== 1'b0) begin
            report_error("config_finished high during a run");
        end
        run_frames++;
        total_frames++;
    end

    task automatic run_config(input logic tp, input img_mode_t mode,
                              input logic [2:0] res, input logic [6:0] ck);
        exp_tp     = tp;
        exp_mode   = mode;
        exp_res    = res;
        exp_clkrc  = ck;
        run_frames = 0;
        write_reg(REG_CLKRC, {1'b0, ck});
        write_reg(REG_CTRL, {1'b0, res, mode, tp, 1'b1});
        @(negedge config_finished);
        @(posedge config_finished);
        repeat (2) @(negedge clk);
        if (run_frames != 7) begin
            report_error($sformatf("run gave %0d frames instead of 7", run_frames));
        end
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        logic [7:0]  rd;
        logic [31:0] r;
        int          e0;

        wr           = 1'b0;
        wr_addr      = 1'b0;
        wr_data      = 8'h00;
        rd_addr      = 1'b0;
        rst          = 1'b1;
        lfsr         = 32'h2335_27f7;
        n_errors     = 0;
        n_checks     = 0;
        run_frames   = 0;
        total_frames = 0;
        release_errs = 0;
        dc_seen      = 0;
        in_frame     = 1'b0;
        exp_tp       = 1'b0;
        exp_mode     = yuv422;
        exp_res      = 3'd0;
        exp_clkrc    = 7'd1;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // reset state
        e0 = n_errors;
        check_val("sioc", 1, sioc);
        check_val("siod", 1, siod);
        repeat (2) @(negedge clk);
        check_val("config_finished", 1, config_finished);
        read_reg(REG_CTRL, rd);
        check_val("rd_data ctrl", 8'h00, rd);
        read_reg(REG_CLKRC, rd);
        check_val("rd_data clkrc", 8'h01, rd);
        if (frame_q.size() != 0 || in_frame) begin
            report_error("bus activity after reset");
        end
        end_test("1 reset state", e0);

        // register access with top bits dropped
        e0 = n_errors;
        write_reg(REG_CTRL, 8'hF6);
        write_reg(REG_CLKRC, 8'hD5);
        read_reg(REG_CTRL, rd);
        check_val("rd_data ctrl", 8'h76, rd);
        read_reg(REG_CLKRC, rd);
        check_val("rd_data clkrc", 8'h55, rd);
        end_test("2 register access", e0);

        // first configuration run
        e0 = n_errors;
        run_config(1'b1, rgb565, 3'd4, 7'd3);
        end_test("3 base configuration", e0);

        // update clears itself and nothing else goes out
        e0 = n_errors;
        read_reg(REG_CTRL, rd);
        check_val("rd_data ctrl", {1'b0, 3'd4, rgb565, 1'b1, 1'b0}, rd);
        #(2 * FRAME_NS);
        if (run_frames != 7 || frame_q.size() != 0 || in_frame) begin
            report_error("frames seen after the run ended");
        end
        end_test("4 update self-clear", e0);

        // random settings
        e0 = n_errors;
        for (int i = 0; i < 4; i++) begin
            take_bits(13, r);
            run_config(r[12], img_mode_t'(r[11:10]), r[9:7], r[6:0]);
        end
        end_test("5 random configurations", e0);

        // line release over all frames
        e0 = n_errors;
        check_val("release errors", 0, release_errs);
        check_val("dont-care bits", 3 * total_frames, dc_seen);
        end_test("6 line release", e0);

        $display("checks %0d, errors %0d, frames %0d", n_checks, n_errors, total_frames);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
src/cam_cfg_pkg.sv
src/cam_ctrl_regs.sv
src/cam_cmd_table.sv
src/sccb_master.sv
src/cam_cfg_top.sv
verif/sccb_master_assert.sv
verif/cam_cfg_tb.sv

// ==== Bender.yml ====
package:
  name: cam_cfg

sources:
  - src/cam_cfg_pkg.sv
  - src/cam_ctrl_regs.sv
  - src/cam_cmd_table.sv
  - src/sccb_master.sv
  - src/cam_cfg_top.sv
  - target: test
    files:
      - verif/sccb_master_assert.sv
      - verif/cam_cfg_tb.sv
